/* source/uart_dbg_consts.svh */
// Build-time constants for the UART debug bridge
// UART_CLKS_PER_BIT must be at least 4; DBG_MEM_BYTES must be a power of two
// Parity, when enabled, is even and follows the eight data bits

`ifndef UART_DBG_CONSTS_SVH
`define UART_DBG_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial line
////////////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// 1 adds an even-parity bit after the data bits
`define UART_PARITY_ENA 1

////////////////////////////////////////////////////////////////////////////
// Debug memory
////////////////////////////////////////////////////////////////////////////

// Addresses wrap modulo this size
`define DBG_MEM_BYTES 256

////////////////////////////////////////////////////////////////////////////
// Protocol byte codes
////////////////////////////////////////////////////////////////////////////

`define DBG_CMD_READ  8'h11
`define DBG_CMD_WRITE 8'h12
`define DBG_CMD_EXEC  8'h13
`define DBG_ACK       8'h06
`define DBG_EOT       8'h04
`define DBG_EOC       8'h14

`endif

/* source/uart_dbg_pkg.sv */
// Types shared by the debug bridge RTL and its testbench
// Memory address width follows DBG_MEM_BYTES from the constants header

`include "uart_dbg_consts.svh"

package uart_dbg_pkg;

  // Width of a wrapped memory address
  localparam int unsigned MEM_AW = $clog2(`DBG_MEM_BYTES);

  typedef logic [7:0] dbg_byte_t;

  // One received UART frame
  typedef struct packed {
    dbg_byte_t data;
    logic      parity_err;
  } rx_frame_t;

  // Entry point handed out on EXEC
  typedef struct packed {
    logic [63:0] addr;
  } exec_req_t;

  // Exit code returned by the host side
  typedef struct packed {
    logic [31:0] code;
  } eoc_req_t;

  // Byte access to the debug memory
  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;
    dbg_byte_t         wdata;
  } mem_req_t;

endpackage

/* source/uart_rx.sv */
// Oversampled UART receiver, 8 data bits LSB first, one stop bit
// A stop bit sampled low is not flagged; the frame is still delivered

`include "uart_dbg_consts.svh"

module uart_rx import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      uart_rx_i,
  output logic      rx_valid_o,
  output rx_frame_t rx_frame_o
);

  localparam int unsigned CLKS   = `UART_CLKS_PER_BIT;
  localparam int unsigned CNT_W  = $clog2(CLKS);
  localparam bit          PAR_EN = (`UART_PARITY_ENA != 0);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  rx_state_e  state_q;
  logic [1:0] sync_q;
  logic       line;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0] bit_idx_q;
  dbg_byte_t  shift_q;
  logic       par_q;
  logic       tick;

  // Two-flop synchronizer, idle high out of reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], uart_rx_i};
    end
  end

  assign line = sync_q[1];
  assign tick = (cnt_q == '0);

  // Bit-time state machine
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (state_q != RX_IDLE && !tick) begin
        cnt_q <= cnt_q - 1'b1;
      end
      case (state_q)
        RX_IDLE: begin
          // Half a bit to land in the middle of the start bit
          if (!line) begin
            state_q <= RX_START;
            cnt_q   <= CNT_W'(CLKS / 2 - 1);
          end
        end
        RX_START: begin
          if (tick) begin
            // Glitch on the line, not a real start bit
            state_q   <= line ? RX_IDLE : RX_DATA;
            cnt_q     <= CNT_W'(CLKS - 1);
            bit_idx_q <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            cnt_q     <= CNT_W'(CLKS - 1);
            if (bit_idx_q == 3'd7) begin
              state_q <= PAR_EN ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (tick) begin
            state_q <= RX_STOP;
            cnt_q   <= CNT_W'(CLKS - 1);
          end
        end
        default: begin
          // Middle of the stop bit, hand the frame over
          if (tick) begin
            state_q    <= RX_IDLE;
            rx_valid_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // Shift register and received parity bit
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && tick) begin
      shift_q <= {line, shift_q[7:1]};
    end
    if (state_q == RX_PARITY && tick) begin
      par_q <= line;
    end
    if (state_q == RX_STOP && tick) begin
      rx_frame_o.data       <= shift_q;
      rx_frame_o.parity_err <= PAR_EN && ((^shift_q) ^ par_q);
    end
  end

endmodule

/* source/uart_tx.sv */
// UART transmitter, one frame per strobe on tx_valid_i
// Strobes while tx_busy_o is high are ignored

`include "uart_dbg_consts.svh"

module uart_tx import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      tx_valid_i,
  input  dbg_byte_t tx_data_i,
  output logic      tx_busy_o,
  output logic      uart_tx_o
);

  localparam int unsigned CLKS   = `UART_CLKS_PER_BIT;
  localparam int unsigned CNT_W  = $clog2(CLKS);
  localparam bit          PAR_EN = (`UART_PARITY_ENA != 0);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  tx_state_e  state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0] bit_idx_q;
  dbg_byte_t  shift_q;
  logic       par_q;
  logic       tick;

  assign tick      = (cnt_q == '0);
  assign tx_busy_o = (state_q != TX_IDLE);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      uart_tx_o <= 1'b1;
    end else begin
      if (state_q != TX_IDLE) begin
        cnt_q <= tick ? CNT_W'(CLKS - 1) : cnt_q - 1'b1;
      end
      case (state_q)
        TX_IDLE: begin
          // Start bit goes out on the next cycle
          if (tx_valid_i) begin
            state_q   <= TX_START;
            cnt_q     <= CNT_W'(CLKS - 1);
            uart_tx_o <= 1'b0;
          end
        end
        TX_START: begin
          if (tick) begin
            state_q   <= TX_DATA;
            bit_idx_q <= '0;
            uart_tx_o <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (tick) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q   <= PAR_EN ? TX_PARITY : TX_STOP;
              uart_tx_o <= PAR_EN ? par_q : 1'b1;
            end else begin
              uart_tx_o <= shift_q[1];
            end
          end
        end
        TX_PARITY: begin
          if (tick) begin
            state_q   <= TX_STOP;
            uart_tx_o <= 1'b1;
          end
        end
        default: begin
          if (tick) begin
            state_q <= TX_IDLE;
          end
        end
      endcase
    end
  end

  // Byte and even parity, captured at the strobe
  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && tx_valid_i) begin
      shift_q <= tx_data_i;
      par_q   <= ^tx_data_i;
    end else if (state_q == TX_DATA && tick) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

/* source/dbg_cmd_engine.sv */
// Debug command parser and response sequencer
// Only the low 16 length bits are honoured; addresses wrap to the memory size
// Bytes that arrive while a response is being sent are dropped

`include "uart_dbg_consts.svh"

module dbg_cmd_engine import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      rx_valid_i,
  input  rx_frame_t rx_frame_i,
  output logic      tx_valid_o,
  output dbg_byte_t tx_data_o,
  input  logic      tx_busy_i,
  output logic      mem_valid_o,
  output mem_req_t  mem_req_o,
  input  dbg_byte_t mem_rdata_i,
  output logic      exec_valid_o,
  output exec_req_t exec_o,
  input  logic      eoc_valid_i,
  input  eoc_req_t  eoc_i
);

  typedef enum logic [3:0] {
    S_IDLE, S_ADDR, S_LEN, S_ACK, S_ECHO, S_WDATA, S_RREQ, S_RSEND, S_EOT, S_EOC
  } state_e;

  state_e            state_q;
  logic [2:0]        cnt_q;
  dbg_byte_t         cmd_q;
  logic [63:0]       addr_q;
  logic [15:0]       len_q;
  logic [MEM_AW-1:0] mem_addr_q;
  logic              exec_valid_q;
  logic              eoc_pending_q;
  eoc_req_t          eoc_code_q;
  logic [31:0]       eoc_shift_q;
  logic              rx_ok;
  logic              tx_req;
  logic              eoc_start;

  // Frames with a parity error never reach the parser
  assign rx_ok     = rx_valid_i && !rx_frame_i.parity_err;
  assign eoc_start = (state_q == S_IDLE) && !rx_ok && eoc_pending_q;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit and memory requests
  ////////////////////////////////////////////////////////////////////////////

  assign tx_req = (state_q == S_ACK) || (state_q == S_ECHO) || (state_q == S_RSEND) ||
                  (state_q == S_EOT) || (state_q == S_EOC);
  assign tx_valid_o = tx_req && !tx_busy_i;

  always_comb begin
    case (state_q)
      S_EOT:   tx_data_o = `DBG_EOT;
      S_RSEND: tx_data_o = mem_rdata_i;
      S_EOC:   tx_data_o = (cnt_q == 3'd0) ? `DBG_EOC : eoc_shift_q[7:0];
      default: tx_data_o = `DBG_ACK;
    endcase
  end

  assign mem_valid_o     = (state_q == S_WDATA && rx_ok) || (state_q == S_RREQ);
  assign mem_req_o.we    = (state_q == S_WDATA);
  assign mem_req_o.addr  = mem_addr_q;
  assign mem_req_o.wdata = rx_frame_i.data;

  assign exec_valid_o = exec_valid_q;
  assign exec_o.addr  = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q       <= S_IDLE;
      cnt_q         <= '0;
      exec_valid_q  <= 1'b0;
      eoc_pending_q <= 1'b0;
    end else begin
      exec_valid_q <= 1'b0;
      // A newer exit code replaces a pending one
      if (eoc_valid_i) begin
        eoc_pending_q <= 1'b1;
      end else if (eoc_start) begin
        eoc_pending_q <= 1'b0;
      end
      case (state_q)
        S_IDLE: begin
          cnt_q <= '0;
          if (rx_ok) begin
            case (rx_frame_i.data)
              `DBG_ACK: state_q <= S_ECHO;
              `DBG_CMD_READ, `DBG_CMD_WRITE, `DBG_CMD_EXEC: state_q <= S_ADDR;
              default: state_q <= S_IDLE;
            endcase
          end else if (eoc_start) begin
            state_q <= S_EOC;
          end
        end
        S_ADDR: begin
          if (rx_ok) begin
            cnt_q <= cnt_q + 3'd1;
            if (cnt_q == 3'd7) begin
              state_q <= (cmd_q == `DBG_CMD_EXEC) ? S_ACK : S_LEN;
            end
          end
        end
        S_LEN: begin
          if (rx_ok) begin
            cnt_q <= cnt_q + 3'd1;
            if (cnt_q == 3'd7) begin
              state_q <= S_ACK;
            end
          end
        end
        S_ACK: begin
          if (tx_valid_o) begin
            if (cmd_q == `DBG_CMD_EXEC) begin
              exec_valid_q <= 1'b1;
              state_q      <= S_IDLE;
            end else if (len_q == '0) begin
              state_q <= S_EOT;
            end else begin
              state_q <= (cmd_q == `DBG_CMD_WRITE) ? S_WDATA : S_RREQ;
            end
          end
        end
        S_WDATA: begin
          if (rx_ok && len_q == 16'd1) begin
            state_q <= S_EOT;
          end
        end
        S_RREQ: state_q <= S_RSEND;
        S_RSEND: begin
          if (tx_valid_o) begin
            state_q <= (len_q == 16'd1) ? S_EOT : S_RREQ;
          end
        end
        S_EOC: begin
          // Code byte, then four exit-code bytes
          if (tx_valid_o) begin
            cnt_q <= cnt_q + 3'd1;
            if (cnt_q == 3'd4) begin
              state_q <= S_IDLE;
            end
          end
        end
        default: begin
          if (tx_valid_o) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command fields and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && rx_ok) begin
      cmd_q <= rx_frame_i.data;
    end
    // Address arrives low byte first
    if (state_q == S_ADDR && rx_ok) begin
      addr_q <= {rx_frame_i.data, addr_q[63:8]};
    end
    if (state_q == S_LEN && rx_ok && cnt_q == 3'd0) begin
      len_q[7:0] <= rx_frame_i.data;
    end else if (state_q == S_LEN && rx_ok && cnt_q == 3'd1) begin
      len_q[15:8] <= rx_frame_i.data;
    end else if ((state_q == S_WDATA && rx_ok) || (state_q == S_RSEND && tx_valid_o)) begin
      len_q <= len_q - 16'd1;
    end
    if (state_q == S_ACK) begin
      mem_addr_q <= addr_q[MEM_AW-1:0];
    end else if (mem_valid_o) begin
      mem_addr_q <= mem_addr_q + 1'b1;
    end
    if (eoc_valid_i) begin
      eoc_code_q <= eoc_i;
    end
    if (eoc_start) begin
      eoc_shift_q <= eoc_code_q.code;
    end else if (state_q == S_EOC && tx_valid_o && cnt_q != 3'd0) begin
      eoc_shift_q <= eoc_shift_q >> 8;
    end
  end

endmodule

/* source/dbg_mem.sv */
// Byte-wide debug memory, synchronous write and registered read
// Contents are undefined until written; rdata_o only changes on a read

`include "uart_dbg_consts.svh"

module dbg_mem import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      mem_valid_i,
  input  mem_req_t  mem_req_i,
  output dbg_byte_t rdata_o
);

  dbg_byte_t mem_q [`DBG_MEM_BYTES];

  // One port, write or read per request
  always_ff @(posedge clk) begin
    if (mem_valid_i) begin
      if (mem_req_i.we) begin
        mem_q[mem_req_i.addr] <= mem_req_i.wdata;
      end else begin
        rdata_o <= mem_q[mem_req_i.addr];
      end
    end
  end

endmodule

/* source/uart_dbg_bridge.sv */
// UART debug bridge: serial line in and out, on-chip byte memory
// parity_error_o pulses once per frame received with bad parity

module uart_dbg_bridge import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output logic      parity_error_o,
  output logic      exec_valid_o,
  output exec_req_t exec_o,
  input  logic      eoc_valid_i,
  input  eoc_req_t  eoc_i
);

  logic      rx_valid;
  rx_frame_t rx_frame;
  logic      tx_valid;
  dbg_byte_t tx_data;
  logic      tx_busy;
  logic      mem_valid;
  mem_req_t  mem_req;
  dbg_byte_t mem_rdata;

  uart_rx rx_i (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .uart_rx_i  ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_frame_o ( rx_frame  )
  );

  assign parity_error_o = rx_valid && rx_frame.parity_err;

  dbg_cmd_engine engine_i (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .rx_valid_i   ( rx_valid     ),
    .rx_frame_i   ( rx_frame     ),
    .tx_valid_o   ( tx_valid     ),
    .tx_data_o    ( tx_data      ),
    .tx_busy_i    ( tx_busy      ),
    .mem_valid_o  ( mem_valid    ),
    .mem_req_o    ( mem_req      ),
    .mem_rdata_i  ( mem_rdata    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_o       ( exec_o       ),
    .eoc_valid_i  ( eoc_valid_i  ),
    .eoc_i        ( eoc_i        )
  );

  dbg_mem mem_i (
    .clk         ( clk       ),
    .mem_valid_i ( mem_valid ),
    .mem_req_i   ( mem_req   ),
    .rdata_o     ( mem_rdata )
  );

  uart_tx tx_i (
    .clk        ( clk       ),
    .reset_i    ( reset_i   ),
    .tx_valid_i ( tx_valid  ),
    .tx_data_i  ( tx_data   ),
    .tx_busy_o  ( tx_busy   ),
    .uart_tx_o  ( uart_tx_o )
  );

endmodule

/* tb/tb_uart_dbg_bridge.sv */
// Self-checking testbench for the UART debug bridge
// Run from the project root so the data file path resolves
// Actions and expected responses come from tb/tb_uart_dbg_input.txt
// Expects even parity when UART_PARITY_ENA is set

`include "uart_dbg_consts.svh"

module tb_uart_dbg_bridge import uart_dbg_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLKS       = `UART_CLKS_PER_BIT;
  localparam bit PAR_EN     = (`UART_PARITY_ENA != 0);
  localparam int FRAME_CLKS = (10 + PAR_EN) * CLKS;

  logic      clk;
  logic      reset_i;
  logic      uart_rx_i;
  logic      uart_tx_o;
  logic      parity_error_o;
  logic      exec_valid_o;
  exec_req_t exec_o;
  logic      eoc_valid_i;
  eoc_req_t  eoc_i;

  int          errors = 0;
  int          parity_pulses = 0;
  int          n_items = 0;
  bit          loaded = 1'b0;
  string       lines[$];
  logic [63:0] line_vals[$];
  dbg_byte_t   tx_q[$];
  exec_req_t   exec_q[$];

  uart_dbg_bridge dut_i (
    .clk            ( clk            ),
    .reset_i        ( reset_i        ),
    .uart_rx_i      ( uart_rx_i      ),
    .uart_tx_o      ( uart_tx_o      ),
    .parity_error_o ( parity_error_o ),
    .exec_valid_o   ( exec_valid_o   ),
    .exec_o         ( exec_o         ),
    .eoc_valid_i    ( eoc_valid_i    ),
    .eoc_i          ( eoc_i          )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input dbg_byte_t exp, input dbg_byte_t act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_exec(input exec_req_t exp, input exec_req_t act);
    if (act !== exp) begin
      $display("ERR exec_o expected 0x%h got 0x%h", exp.addr, act.addr);
      errors++;
    end
  endtask

  task automatic check_parity_flag(input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR parity_error_o expected 0x%h got 0x%h", exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (parity_error_o === 1'b1) begin
      parity_pulses++;
    end
    if (exec_valid_o === 1'b1) begin
      exec_q.push_back(exec_o);
    end
  end

  // Serial decoder that samples uart_tx_o in the middle of each bit
  initial begin
    dbg_byte_t rx_byte;
    logic      par_bit;
    forever begin
      @(negedge clk);
      if (uart_tx_o === 1'b0) begin
        repeat (CLKS / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS) @(negedge clk);
          rx_byte[i] = uart_tx_o;
        end
        if (PAR_EN) begin
          repeat (CLKS) @(negedge clk);
          par_bit = uart_tx_o;
          if (par_bit !== ^rx_byte) begin
            $display("Frame 0x%h from the DUT has a wrong parity bit", rx_byte);
            errors++;
          end
        end
        repeat (CLKS) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
          $display("Frame 0x%h from the DUT has no stop bit", rx_byte);
          errors++;
        end
        tx_q.push_back(rx_byte);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic hold_bit(input logic b);
    uart_rx_i <= b;
    repeat (CLKS) @(posedge clk);
  endtask

  // Start, data LSB first, parity, stop and two idle bits
  task automatic send_frame(input dbg_byte_t data, input logic bad_par);
    @(posedge clk);
    hold_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      hold_bit(data[i]);
    end
    if (PAR_EN) begin
      hold_bit((^data) ^ bad_par);
    end
    repeat (3) hold_bit(1'b1);
  endtask

  task automatic send_checked(input dbg_byte_t data, input logic bad_par);
    int pulses_before;
    pulses_before = parity_pulses;
    send_frame(data, bad_par);
    check_parity_flag(bad_par && PAR_EN, parity_pulses != pulses_before);
  endtask

  task automatic expect_byte(input dbg_byte_t exp);
    int waited;
    waited = 0;
    while (tx_q.size() == 0 && waited < 3 * FRAME_CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (tx_q.size() == 0) begin
      $display("No byte on uart_tx_o where 0x%h was expected", exp);
      errors++;
    end else begin
      check_byte("uart_tx_o", exp, tx_q.pop_front());
    end
  endtask

  task automatic expect_exec(input logic [63:0] addr);
    exec_req_t exp;
    int        waited;
    exp.addr = addr;
    waited = 0;
    while (exec_q.size() == 0 && waited < FRAME_CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (exec_q.size() == 0) begin
      $display("No exec strobe where entry 0x%h was expected", addr);
      errors++;
    end else begin
      check_exec(exp, exec_q.pop_front());
    end
  endtask

  task automatic pulse_eoc(input logic [31:0] code);
    @(posedge clk);
    eoc_valid_i <= 1'b1;
    eoc_i.code  <= code;
    @(posedge clk);
    eoc_valid_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Data file parsing
  ////////////////////////////////////////////////////////////////////////////

  function automatic int hex_digit(input byte c);
    if (c >= "0" && c <= "9") return c - "0";
    if (c >= "a" && c <= "f") return c - "a" + 10;
    if (c >= "A" && c <= "F") return c - "A" + 10;
    return -1;
  endfunction

  // Fills line_vals with the hex values after the action letter
  function automatic void parse_values(input string text);
    logic [63:0] acc;
    bit          in_tok;
    byte         c;
    int          d;
    line_vals.delete();
    if (!(text.getc(0) inside {"S", "B", "E", "X", "C"})) return;
    acc = '0;
    in_tok = 1'b0;
    for (int i = 1; i <= text.len(); i++) begin
      c = (i < text.len()) ? text.getc(i) : 8'h20;
      d = hex_digit(c);
      if (d >= 0) begin
        acc = {acc[59:0], d[3:0]};
        in_tok = 1'b1;
      end else if (in_tok) begin
        line_vals.push_back(acc);
        acc = '0;
        in_tok = 1'b0;
      end
    end
  endfunction

  task automatic run_line(input string text);
    byte act;
    act = text.getc(0);
    parse_values(text);
    foreach (line_vals[k]) begin
      case (act)
        "S": send_checked(line_vals[k][7:0], 1'b0);
        "B": send_checked(line_vals[k][7:0], 1'b1);
        "E": expect_byte(line_vals[k][7:0]);
        "X": expect_exec(line_vals[k]);
        "C": pulse_eoc(line_vals[k][31:0]);
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    string text;
    uart_rx_i   = 1'b1;
    eoc_valid_i = 1'b0;
    eoc_i       = '0;
    reset_i     = 1'b1;
    fd = $fopen("tb/tb_uart_dbg_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/tb_uart_dbg_input.txt");
      errors++;
    end else begin
      while ($fgets(text, fd) > 0) begin
        lines.push_back(text);
        parse_values(text);
        n_items += line_vals.size();
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    repeat (2 * CLKS) @(posedge clk);
    foreach (lines[n]) begin
      run_line(lines[n]);
    end
    // Let any stray response arrive before the final checks
    repeat (2 * FRAME_CLKS) @(negedge clk);
    if (tx_q.size() != 0) begin
      $display("%0d unexpected bytes on uart_tx_o, first 0x%h", tx_q.size(), tx_q[0]);
      errors++;
    end
    if (exec_q.size() != 0) begin
      $display("%0d unexpected exec strobes", exec_q.size());
      errors++;
    end
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Budget of twice 14 bit times per value plus margin for reset and drain
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(n_items + 4) * 14 * CLKS * 20 * 2;
    #(limit_ns);
    $display("Timeout after %0d ns, the DUT stopped responding", limit_ns);
    $display("test failed");
    $finish;
  end

endmodule

/* tb/tb_uart_dbg_input.txt */
# Columns: action letter, then hex values. S send, B send with bad parity,
# E expect byte on uart_tx_o, X expect exec entry address, C end-of-computation code
# ACK challenge
S 06
E 06
# WRITE 5 bytes at 0x20, address bits above the memory size set
S 12 20 00 00 00 01 00 00 00 05 00 00 00 00 00 00 00
E 06
S 3a c1 7e 05 d9
E 04
# READ the same 5 bytes back
S 11 20 00 00 00 00 00 00 00 05 00 00 00 00 00 00 00
E 06 3a c1 7e 05 d9 04
# WRITE 4 bytes across the top of memory
S 12 fe 00 00 00 00 00 00 00 04 00 00 00 00 00 00 00
E 06
S 8b 42 e7 19
E 04
# READ 2 bytes at address 0 returns the wrapped tail
S 11 00 00 00 00 00 00 00 00 02 00 00 00 00 00 00 00
E 06 e7 19 04
# READ of length 0
S 11 40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
E 06 04
# EXEC
S 13 00 10 00 80 00 00 00 00
E 06
X 0000000080001000
# End of computation
C deadbeef
E 14 ef be ad de
# Bad parity is dropped, the next challenge still works
B 06
S 06
E 06

/* project.f */
+incdir+source
source/uart_dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/dbg_cmd_engine.sv
source/dbg_mem.sv
source/uart_dbg_bridge.sv
tb/tb_uart_dbg_bridge.sv

/* Bender.yml */
package:
  name: uart_dbg_bridge

sources:
  - include_dirs:
      - source
    files:
      - source/uart_dbg_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/dbg_cmd_engine.sv
      - source/dbg_mem.sv
      - source/uart_dbg_bridge.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_uart_dbg_bridge.sv
